/* common/soc_pkg.sv */
//********************
// Shared widths, slot map, register offsets and state types of the
// system-control block. Every module refers to them by scoped name.
//********************
`default_nettype none

package soc_pkg;

	// Bus widths
	localparam int unsigned DATA_W = 32;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [31:0] addr_t;

	// Slot index comes from address bits 13:12, word offset from bits 5:2
	typedef logic [1:0] slot_t;
	typedef logic [3:0] reg_off_t;

	localparam int unsigned INT_SRC_COUNT = 2;
	typedef logic [INT_SRC_COUNT-1:0] irq_vec_t;

	// Slot map with 4 KB per slot
	localparam slot_t SLOT_DEVTBL  = 2'd0;
	localparam slot_t SLOT_INTCTRL = 2'd1;
	localparam slot_t SLOT_INVALID = 2'd2;
	localparam int unsigned SLOT_COUNT = 3;
	localparam data_t SLOT_MAP_WORDS = 32'd1024;

	// Device table contents
	localparam data_t SOC_ID = 32'd6;
	localparam logic [7:0] DEVID_DEVTBL  = 8'd7;
	localparam logic [7:0] DEVID_INTCTRL = 8'd3;
	localparam logic [7:0] DEVID_INVALID = 8'd0;
	// No slot raises interrupts through the controller
	localparam logic [SLOT_COUNT-1:0] SLOT_USEINTR = '0;

	// Device table word offsets
	localparam reg_off_t DT_OFF_SOCID  = 4'd0;
	localparam reg_off_t DT_OFF_COUNT  = 4'd1;
	localparam reg_off_t DT_OFF_RSTCTL = 4'd2;
	localparam reg_off_t DT_OFF_DESC   = 4'd4;
	localparam reg_off_t DT_OFF_MAPSZ  = 4'd8;

	// Interrupt controller word offsets
	localparam reg_off_t IC_OFF_PEND = 4'd0;
	localparam reg_off_t IC_OFF_EN   = 4'd1;

	// Reset sequencing
	localparam int unsigned RST_HOLD_CYCLES = 16;
	typedef logic [3:0] rst_cnt_t;
	typedef enum logic [1:0] {
		RST_REQ_NONE,
		RST_REQ_WARM,
		RST_REQ_PWROFF
	} rst_req_t;

	// State machines
	typedef enum logic [1:0] {BUS_IDLE, BUS_WRESP, BUS_RRESP} bus_state_t;
	typedef enum logic [1:0] {RST_HOLD, RST_RUN, RST_OFF} rst_state_t;

endpackage

`default_nettype wire

/* dv/soc_tb_axi.svh */
//********************
// AXI4-Lite host tasks, included inside the testbench module.
// They drive on the falling edge and sample before each rising edge.
//********************
`ifndef SOC_TB_AXI_SVH
`define SOC_TB_AXI_SVH

task automatic axi_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data);
	logic accepted;
	logic done;
	@(negedge clk48mhz);
	axi_awaddr = addr;
	axi_wdata = data;
	axi_awvalid = 1'b1;
	axi_wvalid = 1'b1;
	accepted = 1'b0;
	while (!accepted) begin
		@(posedge clk48mhz);
		accepted = axi_awready && axi_wready;
	end
	@(negedge clk48mhz);
	axi_awvalid = 1'b0;
	axi_wvalid = 1'b0;
	chk_cnt++;
	if (!axi_bvalid) begin
		err_cnt++;
		$display("Write response did not follow acceptance by one cycle at %h", addr);
	end
	// Back-pressure on the response channel
	repeat ($urandom_range(3, 0)) @(negedge clk48mhz);
	axi_bready = 1'b1;
	done = 1'b0;
	while (!done) begin
		@(posedge clk48mhz);
		done = axi_bvalid;
	end
	@(negedge clk48mhz);
	axi_bready = 1'b0;
endtask

task automatic axi_read(input soc_pkg::addr_t addr, output soc_pkg::data_t data);
	logic accepted;
	logic done;
	@(negedge clk48mhz);
	axi_araddr = addr;
	axi_arvalid = 1'b1;
	accepted = 1'b0;
	while (!accepted) begin
		@(posedge clk48mhz);
		accepted = axi_arready;
	end
	@(negedge clk48mhz);
	axi_arvalid = 1'b0;
	chk_cnt++;
	if (!axi_rvalid) begin
		err_cnt++;
		$display("Read data did not follow acceptance by one cycle at %h", addr);
	end
	repeat ($urandom_range(3, 0)) @(negedge clk48mhz);
	axi_rready = 1'b1;
	done = 1'b0;
	while (!done) begin
		@(posedge clk48mhz);
		done = axi_rvalid;
		// Data is taken at the handshake, after any back-pressure
		data = axi_rdata;
	end
	@(negedge clk48mhz);
	axi_rready = 1'b0;
endtask

`endif

/* dv/soc_tb.sv */
//********************
// Testbench for the system-control top level. A table of bus, interrupt
// and reset steps is applied in a loop and mismatches are counted.
//********************
`timescale 1ns/10ps
`default_nettype none

module soc_tb;

	localparam int unsigned MAX_ROWS = 64;
	localparam int unsigned HOLD = soc_pkg::RST_HOLD_CYCLES;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_SRC, OP_IRQ, OP_WARM, OP_PWROFF} op_t;

	logic clk48mhz;
	logic rst_p;
	soc_pkg::addr_t axi_awaddr;
	soc_pkg::addr_t axi_araddr;
	soc_pkg::data_t axi_wdata;
	soc_pkg::data_t axi_rdata;
	logic axi_awvalid, axi_awready, axi_wvalid, axi_wready;
	logic axi_bvalid, axi_bready, axi_arvalid, axi_arready;
	logic axi_rvalid, axi_rready;
	soc_pkg::irq_vec_t irq_src;
	logic irq, soc_rst, pwroff;

	int err_cnt;
	int chk_cnt;
	int row_cnt;
	int cycle_cnt;
	int timeout_limit;
	soc_pkg::irq_vec_t en_mask;

	string tbl_name [MAX_ROWS];
	op_t tbl_op [MAX_ROWS];
	soc_pkg::addr_t tbl_addr [MAX_ROWS];
	soc_pkg::data_t tbl_wdata [MAX_ROWS];
	soc_pkg::data_t tbl_exp [MAX_ROWS];

	`include "soc_tb_axi.svh"

	soc_top dut0 (
		 .clk48mhz_i (clk48mhz), .rst_p (rst_p)
		,.axi_awaddr_i (axi_awaddr), .axi_awvalid_i (axi_awvalid), .axi_awready_o (axi_awready)
		,.axi_wdata_i (axi_wdata), .axi_wvalid_i (axi_wvalid), .axi_wready_o (axi_wready)
		,.axi_bvalid_o (axi_bvalid), .axi_bready_i (axi_bready)
		,.axi_araddr_i (axi_araddr), .axi_arvalid_i (axi_arvalid), .axi_arready_o (axi_arready)
		,.axi_rdata_o (axi_rdata), .axi_rvalid_o (axi_rvalid), .axi_rready_i (axi_rready)
		,.irq_src_i (irq_src), .irq_o (irq), .soc_rst_o (soc_rst), .pwroff_o (pwroff)
	);

	initial begin
		clk48mhz = 1'b0;
		forever #50 clk48mhz = ~clk48mhz;
	end

	task automatic check_value(input string name, input soc_pkg::data_t exp,
		input soc_pkg::data_t act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic add_row(input string name, input op_t op, input soc_pkg::addr_t addr,
		input soc_pkg::data_t wdata, input soc_pkg::data_t exp);
		tbl_name[row_cnt] = name;
		tbl_op[row_cnt] = op;
		tbl_addr[row_cnt] = addr;
		tbl_wdata[row_cnt] = wdata;
		tbl_exp[row_cnt] = exp;
		row_cnt++;
	endtask

	// Reset pulse, then count the hold while a read is offered and refused
	task automatic apply_reset();
		int n;
		@(negedge clk48mhz);
		rst_p = 1'b1;
		repeat (8) @(negedge clk48mhz);
		chk_cnt++;
		if (axi_awready || axi_wready || axi_arready || axi_bvalid || axi_rvalid
			|| irq || pwroff || !soc_rst) begin
			err_cnt++;
			$display("Outputs are not at their reset values while rst_p is high");
		end
		axi_araddr = '0;
		axi_arvalid = 1'b1;
		rst_p = 1'b0;
		n = 0;
		do begin
			@(negedge clk48mhz);
			if (soc_rst) begin
				n++;
				chk_cnt++;
				if (axi_awready || axi_wready || axi_arready) begin
					err_cnt++;
					$display("A ready output was high during the reset hold");
				end
			end
		end while (soc_rst && n < 4 * HOLD);
		axi_arvalid = 1'b0;
		check_value("reset_hold", HOLD, n);
	endtask

	task automatic pulse_source(input soc_pkg::irq_vec_t mask);
		@(negedge clk48mhz);
		irq_src = mask;
		@(negedge clk48mhz);
		irq_src = '0;
	endtask

	task automatic wait_warm();
		int n;
		n = 0;
		while (!soc_rst && n < 8) begin
			@(negedge clk48mhz);
			n++;
		end
		chk_cnt++;
		if (!soc_rst) begin
			err_cnt++;
			$display("System reset did not rise after the warm-reset code");
		end
		n = 0;
		while (soc_rst && n < 4 * HOLD) begin
			@(negedge clk48mhz);
			n++;
		end
		chk_cnt++;
		if (soc_rst) begin
			err_cnt++;
			$display("System reset did not fall after the warm-reset hold");
		end
	endtask

	task automatic check_pwroff();
		int n;
		logic left;
		n = 0;
		while (!pwroff && n < 8) begin
			@(negedge clk48mhz);
			n++;
		end
		left = !pwroff;
		// Must stay off well past a normal hold
		repeat (2 * HOLD) begin
			@(negedge clk48mhz);
			if (!pwroff || !soc_rst)
				left = 1'b1;
		end
		chk_cnt++;
		if (left) begin
			err_cnt++;
			$display("Power-off did not latch with system reset held until rst_p");
		end
		apply_reset();
	endtask

	task automatic build_table();
		soc_pkg::data_t m;
		m = soc_pkg::data_t'(en_mask);
		add_row("dt_socid", OP_RD, 32'h0000, 0, soc_pkg::SOC_ID);
		add_row("dt_count", OP_RD, 32'h0004, 0, 32'd3);
		add_row("dt_rstctl_rd", OP_RD, 32'h0008, 0, 32'd0);
		add_row("dt_unused3", OP_RD, 32'h000C, 0, 32'd0);
		add_row("dt_desc0", OP_RD, 32'h0010, 0, soc_pkg::data_t'(soc_pkg::DEVID_DEVTBL));
		add_row("dt_desc1", OP_RD, 32'h0014, 0, soc_pkg::data_t'(soc_pkg::DEVID_INTCTRL));
		add_row("dt_desc2", OP_RD, 32'h0018, 0, soc_pkg::data_t'(soc_pkg::DEVID_INVALID));
		add_row("dt_unused7", OP_RD, 32'h001C, 0, 32'd0);
		add_row("dt_mapsz0", OP_RD, 32'h0020, 0, 32'd1024);
		add_row("dt_mapsz1", OP_RD, 32'h0024, 0, 32'd1024);
		add_row("dt_mapsz2", OP_RD, 32'h0028, 0, 32'd1024);
		add_row("dt_unused15", OP_RD, 32'h003C, 0, 32'd0);
		add_row("inv_rd_2000", OP_RD, 32'h2000, 0, 32'd0);
		add_row("inv_rd_3000", OP_RD, 32'h3000, 0, 32'd0);
		add_row("inv_rd_8000", OP_RD, 32'h8000, 0, 32'd0);
		add_row("en_wr", OP_WR, 32'h1004, m, 0);
		add_row("en_readback", OP_RD, 32'h1004, 0, m);
		// Writes that would alias the enable word if decoded wrongly
		add_row("inv_wr_2004", OP_WR, 32'h2004, ~m, 0);
		add_row("inv_wr_5004", OP_WR, 32'h5004, ~m, 0);
		add_row("en_after_inv", OP_RD, 32'h1004, 0, m);
		add_row("pend_init", OP_RD, 32'h1000, 0, 32'd0);
		add_row("src0_pulse", OP_SRC, 0, 32'd1, 0);
		add_row("irq_src0", OP_IRQ, 0, 0, soc_pkg::data_t'(|(en_mask & 2'b01)));
		add_row("pend_src0", OP_RD, 32'h1000, 0, 32'd1);
		add_row("src1_pulse", OP_SRC, 0, 32'd2, 0);
		add_row("irq_src1", OP_IRQ, 0, 0, soc_pkg::data_t'(|(en_mask & 2'b11)));
		add_row("pend_both", OP_RD, 32'h1000, 0, 32'd3);
		add_row("en_all", OP_WR, 32'h1004, 32'd3, 0);
		add_row("irq_en_all", OP_IRQ, 0, 0, 32'd1);
		add_row("clr_pend0", OP_WR, 32'h1000, 32'd1, 0);
		add_row("pend_after_clr0", OP_RD, 32'h1000, 0, 32'd2);
		add_row("irq_after_clr0", OP_IRQ, 0, 0, 32'd1);
		add_row("clr_pend1", OP_WR, 32'h1000, 32'd2, 0);
		add_row("pend_after_clr1", OP_RD, 32'h1000, 0, 32'd0);
		add_row("irq_after_clr1", OP_IRQ, 0, 0, 32'd0);
		add_row("src0_pre_warm", OP_SRC, 0, 32'd1, 0);
		add_row("pend_pre_warm", OP_RD, 32'h1000, 0, 32'd1);
		add_row("warm_code", OP_WR, 32'h0008, 32'd2, 0);
		add_row("warm_hold", OP_WARM, 0, 0, 0);
		add_row("en_after_warm", OP_RD, 32'h1004, 0, 32'd0);
		add_row("pend_after_warm", OP_RD, 32'h1000, 0, 32'd0);
		add_row("irq_after_warm", OP_IRQ, 0, 0, 32'd0);
		add_row("pwroff_code", OP_WR, 32'h0008, 32'd1, 0);
		add_row("pwroff_latch", OP_PWROFF, 0, 0, 0);
		add_row("socid_after_off", OP_RD, 32'h0000, 0, soc_pkg::SOC_ID);
		add_row("mapsz1_after_off", OP_RD, 32'h0024, 0, 32'd1024);
	endtask

	task automatic run_row(input int i);
		soc_pkg::data_t rd;
		case (tbl_op[i])
			OP_WR: axi_write(tbl_addr[i], tbl_wdata[i]);
			OP_RD: begin
				axi_read(tbl_addr[i], rd);
				check_value(tbl_name[i], tbl_exp[i], rd);
			end
			OP_SRC: pulse_source(soc_pkg::irq_vec_t'(tbl_wdata[i]));
			OP_IRQ: check_value(tbl_name[i], tbl_exp[i], soc_pkg::data_t'(irq));
			OP_WARM: wait_warm();
			default: check_pwroff();
		endcase
	endtask

	initial begin
		rst_p = 1'b1;
		axi_awaddr = '0;
		axi_awvalid = 1'b0;
		axi_wdata = '0;
		axi_wvalid = 1'b0;
		axi_bready = 1'b0;
		axi_araddr = '0;
		axi_arvalid = 1'b0;
		axi_rready = 1'b0;
		irq_src = '0;
		err_cnt = 0;
		chk_cnt = 0;
		row_cnt = 0;
		cycle_cnt = 0;
		// First draw also seeds the generator for the whole run
		en_mask = soc_pkg::irq_vec_t'($urandom(32'h4257_1129)
			& ((1 << soc_pkg::INT_SRC_COUNT) - 1));
		build_table();
		timeout_limit = row_cnt * 10 + 3 * HOLD + 100;
		apply_reset();
		for (int i = 0; i < row_cnt; i++)
			run_row(i);
		$display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Cycle limit for the whole run
	initial begin
		@(posedge clk48mhz);
		while (cycle_cnt < timeout_limit) begin
			@(posedge clk48mhz);
			cycle_cnt++;
		end
		$display("Run did not finish within %0d cycles, errors: %0d", cycle_cnt, err_cnt);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+dv
common/soc_pkg.sv
hdl/soc_bus_ctrl.sv
hdl/soc_devtbl.sv
hdl/soc_intctrl.sv
hdl/soc_rst_seq.sv
hdl/soc_top.sv
dv/soc_tb.sv

/* hdl/soc_bus_ctrl.sv */
//********************
// AXI4-Lite slave with one transfer in flight. Decodes the slot,
// strobes register writes and captures the selected read word.
//********************
`timescale 1ns/10ps
`default_nettype none

module soc_bus_ctrl (
	input wire clk48mhz_i,
	input wire rst_p,
	input wire soc_pkg::addr_t axi_awaddr_i,
	input wire axi_awvalid_i,
	output logic axi_awready_o,
	input wire soc_pkg::data_t axi_wdata_i,
	input wire axi_wvalid_i,
	output logic axi_wready_o,
	output logic axi_bvalid_o,
	input wire axi_bready_i,
	input wire soc_pkg::addr_t axi_araddr_i,
	input wire axi_arvalid_i,
	output logic axi_arready_o,
	output soc_pkg::data_t axi_rdata_o,
	output logic axi_rvalid_o,
	input wire axi_rready_i,
	input wire soc_rst_i,
	output soc_pkg::reg_off_t reg_off_o,
	output soc_pkg::data_t reg_wdata_o,
	output logic devtbl_wr_o,
	output logic intctrl_wr_o,
	input wire soc_pkg::data_t devtbl_rdata_i,
	input wire soc_pkg::data_t intctrl_rdata_i
);

	soc_pkg::bus_state_t state_q;
	soc_pkg::data_t rdata_q;
	soc_pkg::data_t rd_sel;
	soc_pkg::slot_t wr_slot;
	soc_pkg::slot_t rd_slot;
	logic wr_offer;
	logic wr_acc;
	logic rd_acc;

	function automatic soc_pkg::slot_t decode_slot(input soc_pkg::addr_t addr);
		soc_pkg::slot_t slot;
		slot = addr[13:12];
		// Slot 3 and everything from 0x4000 up falls to the invalid device
		if (addr[31:14] != '0 || slot > soc_pkg::SLOT_INVALID)
			slot = soc_pkg::SLOT_INVALID;
		return slot;
	endfunction

	// Writes take priority over reads at acceptance
	assign wr_offer = axi_awvalid_i || axi_wvalid_i;
	assign wr_acc = (state_q == soc_pkg::BUS_IDLE) && axi_awvalid_i && axi_wvalid_i
		&& !soc_rst_i;
	assign rd_acc = (state_q == soc_pkg::BUS_IDLE) && axi_arvalid_i && !wr_offer
		&& !soc_rst_i;

	assign axi_awready_o = wr_acc;
	assign axi_wready_o = wr_acc;
	assign axi_arready_o = rd_acc;
	assign axi_bvalid_o = (state_q == soc_pkg::BUS_WRESP);
	assign axi_rvalid_o = (state_q == soc_pkg::BUS_RRESP);
	assign axi_rdata_o = rdata_q;

	assign wr_slot = decode_slot(axi_awaddr_i);
	assign rd_slot = decode_slot(axi_araddr_i);

	// Register side is valid only in the acceptance cycle
	assign reg_off_o = wr_acc ? axi_awaddr_i[5:2] : axi_araddr_i[5:2];
	assign reg_wdata_o = axi_wdata_i;
	assign devtbl_wr_o = wr_acc && (wr_slot == soc_pkg::SLOT_DEVTBL);
	assign intctrl_wr_o = wr_acc && (wr_slot == soc_pkg::SLOT_INTCTRL);

	always_comb begin
		case (rd_slot)
			soc_pkg::SLOT_DEVTBL: rd_sel = devtbl_rdata_i;
			soc_pkg::SLOT_INTCTRL: rd_sel = intctrl_rdata_i;
			// Invalid device answers with zero
			default: rd_sel = '0;
		endcase
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			state_q <= soc_pkg::BUS_IDLE;
		end else begin
			case (state_q)
				soc_pkg::BUS_IDLE: begin
					if (wr_acc)
						state_q <= soc_pkg::BUS_WRESP;
					else if (rd_acc)
						state_q <= soc_pkg::BUS_RRESP;
				end
				soc_pkg::BUS_WRESP: begin
					if (axi_bready_i)
						state_q <= soc_pkg::BUS_IDLE;
				end
				soc_pkg::BUS_RRESP: begin
					if (axi_rready_i)
						state_q <= soc_pkg::BUS_IDLE;
				end
				default: state_q <= soc_pkg::BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rd_acc)
			rdata_q <= rd_sel;
	end

	// Read data stays put while the host holds off the response
	a_rdata_hold: assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		(axi_rvalid_o && !axi_rready_i) |=> (axi_rvalid_o && $stable(axi_rdata_o)));

endmodule

`default_nettype wire

/* hdl/soc_devtbl.sv */
//********************
// Read-only device table of the slot map. A write to the reset control
// word turns into a one-cycle request for the reset sequencer.
//********************
`timescale 1ns/10ps
`default_nettype none

module soc_devtbl (
	input wire clk48mhz_i,
	input wire soc_rst_i,
	input wire soc_pkg::reg_off_t reg_off_i,
	input wire soc_pkg::data_t reg_wdata_i,
	input wire wr_i,
	output soc_pkg::data_t rdata_o,
	output soc_pkg::rst_req_t rst_req_o
);

	soc_pkg::rst_req_t rst_req_q;
	soc_pkg::rst_req_t code_req;
	soc_pkg::slot_t tbl_slot;
	logic is_desc;
	logic is_mapsz;

	function automatic logic [7:0] slot_devid(input soc_pkg::slot_t slot);
		case (slot)
			soc_pkg::SLOT_DEVTBL: return soc_pkg::DEVID_DEVTBL;
			soc_pkg::SLOT_INTCTRL: return soc_pkg::DEVID_INTCTRL;
			default: return soc_pkg::DEVID_INVALID;
		endcase
	endfunction

	// Descriptor and map size words come as one per slot
	assign is_desc = (reg_off_i >= soc_pkg::DT_OFF_DESC)
		&& (reg_off_i < soc_pkg::DT_OFF_DESC + soc_pkg::reg_off_t'(soc_pkg::SLOT_COUNT));
	assign is_mapsz = (reg_off_i >= soc_pkg::DT_OFF_MAPSZ)
		&& (reg_off_i < soc_pkg::DT_OFF_MAPSZ + soc_pkg::reg_off_t'(soc_pkg::SLOT_COUNT));
	assign tbl_slot = soc_pkg::slot_t'(reg_off_i - soc_pkg::DT_OFF_DESC);

	always_comb begin
		rdata_o = '0;
		if (reg_off_i == soc_pkg::DT_OFF_SOCID) begin
			rdata_o = soc_pkg::SOC_ID;
		end else if (reg_off_i == soc_pkg::DT_OFF_COUNT) begin
			rdata_o = soc_pkg::data_t'(soc_pkg::SLOT_COUNT);
		end else if (is_desc) begin
			rdata_o[7:0] = slot_devid(tbl_slot);
			rdata_o[31] = soc_pkg::SLOT_USEINTR[tbl_slot];
		end else if (is_mapsz) begin
			rdata_o = soc_pkg::SLOT_MAP_WORDS;
		end
	end

	// Bit 0 is rst0, bit 1 is rst1; the cold code acts as warm
	always_comb begin
		case (reg_wdata_i[1:0])
			2'b11, 2'b10: code_req = soc_pkg::RST_REQ_WARM;
			2'b01: code_req = soc_pkg::RST_REQ_PWROFF;
			default: code_req = soc_pkg::RST_REQ_NONE;
		endcase
	end

	always_ff @(posedge clk48mhz_i) begin
		if (soc_rst_i)
			rst_req_q <= soc_pkg::RST_REQ_NONE;
		else if (wr_i && reg_off_i == soc_pkg::DT_OFF_RSTCTL)
			rst_req_q <= code_req;
		else
			rst_req_q <= soc_pkg::RST_REQ_NONE;
	end

	assign rst_req_o = rst_req_q;

	// A request is a single pulse even under back-to-back writes
	a_req_pulse: assert property (@(posedge clk48mhz_i) disable iff (soc_rst_i)
		(rst_req_o != soc_pkg::RST_REQ_NONE) |=> (rst_req_o == soc_pkg::RST_REQ_NONE));

endmodule

`default_nettype wire

/* hdl/soc_intctrl.sv */
//********************
// Two-source interrupt controller. Rising edges set pending bits,
// software clears them by writing ones, irq_o is pending AND enable.
//********************
`timescale 1ns/10ps
`default_nettype none

module soc_intctrl (
	input wire clk48mhz_i,
	input wire soc_rst_i,
	input wire soc_pkg::reg_off_t reg_off_i,
	input wire soc_pkg::data_t reg_wdata_i,
	input wire wr_i,
	output soc_pkg::data_t rdata_o,
	input wire soc_pkg::irq_vec_t irq_src_i,
	output logic irq_o
);

	soc_pkg::irq_vec_t src_q;
	soc_pkg::irq_vec_t rise;
	soc_pkg::irq_vec_t clr;
	soc_pkg::irq_vec_t pend_q;
	soc_pkg::irq_vec_t en_q;

	// Previous source levels for edge detection
	always_ff @(posedge clk48mhz_i) begin
		src_q <= irq_src_i;
	end

	assign rise = irq_src_i & ~src_q;
	assign clr = (wr_i && reg_off_i == soc_pkg::IC_OFF_PEND) ?
		reg_wdata_i[soc_pkg::INT_SRC_COUNT-1:0] : '0;

	always_ff @(posedge clk48mhz_i) begin
		if (soc_rst_i) begin
			pend_q <= '0;
			en_q <= '0;
		end else begin
			// New edge wins over a clear in the same cycle
			pend_q <= (pend_q & ~clr) | rise;
			if (wr_i && reg_off_i == soc_pkg::IC_OFF_EN)
				en_q <= reg_wdata_i[soc_pkg::INT_SRC_COUNT-1:0];
		end
	end

	always_comb begin
		rdata_o = '0;
		case (reg_off_i)
			soc_pkg::IC_OFF_PEND: rdata_o[soc_pkg::INT_SRC_COUNT-1:0] = pend_q;
			soc_pkg::IC_OFF_EN: rdata_o[soc_pkg::INT_SRC_COUNT-1:0] = en_q;
			default: rdata_o = '0;
		endcase
	end

	assign irq_o = |(pend_q & en_q);

endmodule

`default_nettype wire

/* hdl/soc_rst_seq.sv */
//********************
// Reset sequencer. Holds system reset for a fixed count after rst_p
// or a warm request, and latches power-off until rst_p.
//********************
`timescale 1ns/10ps
`default_nettype none

module soc_rst_seq (
	input wire clk48mhz_i,
	input wire rst_p,
	input var soc_pkg::rst_req_t rst_req_i,
	output logic soc_rst_o,
	output logic pwroff_o
);

	localparam soc_pkg::rst_cnt_t CNT_LOAD = soc_pkg::rst_cnt_t'(soc_pkg::RST_HOLD_CYCLES - 1);

	soc_pkg::rst_state_t state_q;
	soc_pkg::rst_cnt_t cnt_q;
	logic soc_rst_q;

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			state_q <= soc_pkg::RST_HOLD;
			cnt_q <= CNT_LOAD;
			soc_rst_q <= 1'b1;
		end else begin
			// Output lags the state by one edge so the hold spans the full count
			soc_rst_q <= (state_q != soc_pkg::RST_RUN)
				|| (rst_req_i != soc_pkg::RST_REQ_NONE);
			case (state_q)
				soc_pkg::RST_HOLD, soc_pkg::RST_RUN: begin
					if (rst_req_i == soc_pkg::RST_REQ_PWROFF) begin
						state_q <= soc_pkg::RST_OFF;
					end else if (rst_req_i == soc_pkg::RST_REQ_WARM) begin
						state_q <= soc_pkg::RST_HOLD;
						cnt_q <= CNT_LOAD;
					end else if (state_q == soc_pkg::RST_HOLD) begin
						if (cnt_q == '0)
							state_q <= soc_pkg::RST_RUN;
						else
							cnt_q <= cnt_q - 1'b1;
					end
				end
				// Power-off only leaves through rst_p
				soc_pkg::RST_OFF: state_q <= soc_pkg::RST_OFF;
				default: state_q <= soc_pkg::RST_HOLD;
			endcase
		end
	end

	assign soc_rst_o = soc_rst_q;
	assign pwroff_o = (state_q == soc_pkg::RST_OFF);

	// The system stays in reset for as long as it is powered off
	a_off_in_rst: assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		pwroff_o |-> soc_rst_o);

endmodule

`default_nettype wire

/* hdl/soc_top.sv */
//********************
// System-control top level. An AXI4-Lite host drives the device table
// and interrupt controller, with the reset sequencer gating both.
//********************
`timescale 1ns/10ps
`default_nettype none

module soc_top (
	input wire clk48mhz_i,
	input wire rst_p,
	input wire soc_pkg::addr_t axi_awaddr_i,
	input wire axi_awvalid_i,
	output wire axi_awready_o,
	input wire soc_pkg::data_t axi_wdata_i,
	input wire axi_wvalid_i,
	output wire axi_wready_o,
	output wire axi_bvalid_o,
	input wire axi_bready_i,
	input wire soc_pkg::addr_t axi_araddr_i,
	input wire axi_arvalid_i,
	output wire axi_arready_o,
	output wire soc_pkg::data_t axi_rdata_o,
	output wire axi_rvalid_o,
	input wire axi_rready_i,
	input wire soc_pkg::irq_vec_t irq_src_i,
	output wire irq_o,
	output wire soc_rst_o,
	output wire pwroff_o
);

	soc_pkg::reg_off_t reg_off;
	soc_pkg::data_t reg_wdata;
	soc_pkg::data_t devtbl_rdata;
	soc_pkg::data_t intctrl_rdata;
	soc_pkg::rst_req_t rst_req;
	wire devtbl_wr;
	wire intctrl_wr;

	soc_bus_ctrl bus0 (
		 .clk48mhz_i      (clk48mhz_i)
		,.rst_p           (rst_p)
		,.axi_awaddr_i    (axi_awaddr_i)
		,.axi_awvalid_i   (axi_awvalid_i)
		,.axi_awready_o   (axi_awready_o)
		,.axi_wdata_i     (axi_wdata_i)
		,.axi_wvalid_i    (axi_wvalid_i)
		,.axi_wready_o    (axi_wready_o)
		,.axi_bvalid_o    (axi_bvalid_o)
		,.axi_bready_i    (axi_bready_i)
		,.axi_araddr_i    (axi_araddr_i)
		,.axi_arvalid_i   (axi_arvalid_i)
		,.axi_arready_o   (axi_arready_o)
		,.axi_rdata_o     (axi_rdata_o)
		,.axi_rvalid_o    (axi_rvalid_o)
		,.axi_rready_i    (axi_rready_i)
		,.soc_rst_i       (soc_rst_o)
		,.reg_off_o       (reg_off)
		,.reg_wdata_o     (reg_wdata)
		,.devtbl_wr_o     (devtbl_wr)
		,.intctrl_wr_o    (intctrl_wr)
		,.devtbl_rdata_i  (devtbl_rdata)
		,.intctrl_rdata_i (intctrl_rdata)
	);

	soc_devtbl devtbl0 (
		 .clk48mhz_i  (clk48mhz_i)
		,.soc_rst_i   (soc_rst_o)
		,.reg_off_i   (reg_off)
		,.reg_wdata_i (reg_wdata)
		,.wr_i        (devtbl_wr)
		,.rdata_o     (devtbl_rdata)
		,.rst_req_o   (rst_req)
	);

	soc_intctrl intctrl0 (
		 .clk48mhz_i  (clk48mhz_i)
		,.soc_rst_i   (soc_rst_o)
		,.reg_off_i   (reg_off)
		,.reg_wdata_i (reg_wdata)
		,.wr_i        (intctrl_wr)
		,.rdata_o     (intctrl_rdata)
		,.irq_src_i   (irq_src_i)
		,.irq_o       (irq_o)
	);

	soc_rst_seq rstseq0 (
		 .clk48mhz_i (clk48mhz_i)
		,.rst_p      (rst_p)
		,.rst_req_i  (rst_req)
		,.soc_rst_o  (soc_rst_o)
		,.pwroff_o   (pwroff_o)
	);

endmodule

`default_nettype wire
